// ==== hw/dlx_isa_pkg.sv ====
package dlx_isa_pkg;

    // word and field types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] imm26_t;

    //////////////////////////////////////////////////
    // field positions
    // opcode sits in the top six bits of the word
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 26;
    localparam int RS1_MSB    = 25;
    localparam int RS1_LSB    = 21;
    // rs2 doubles as destination for i-type
    localparam int RS2_MSB    = 20;
    localparam int RS2_LSB    = 16;
    localparam int RD_MSB     = 15;
    localparam int RD_LSB     = 11;
    localparam int FUNC_MSB   = 5;
    localparam int FUNC_LSB   = 0;
    localparam int IMM16_MSB  = 15;
    localparam int IMM16_LSB  = 0;
    localparam int IMM26_MSB  = 25;
    localparam int IMM26_LSB  = 0;

    //////////////////////////////////////////////////
    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQZ  = 6'h04;
    localparam opcode_t OP_BNEZ  = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;

    // r-type function codes
    localparam func_t FUNC_ADD = 6'h20;
    localparam func_t FUNC_SUB = 6'h22;
    localparam func_t FUNC_AND = 6'h24;
    localparam func_t FUNC_OR  = 6'h25;
    localparam func_t FUNC_XOR = 6'h26;
    localparam func_t FUNC_SLT = 6'h2a;

endpackage

// ==== hw/dlx_pipe_pkg.sv ====
package dlx_pipe_pkg;

    //////////////////////////////////////////////////
    // internal alu operation codes
    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    // signed compare, result is 0 or 1
    localparam alu_op_t ALU_SLT = 3'd5;

    //////////////////////////////////////////////////
    // fetch constants
    localparam dlx_isa_pkg::word_t RESET_PC = 32'h0000_0000;
    // one 32-bit instruction per step
    localparam dlx_isa_pkg::word_t PC_STEP  = 32'd4;

    // register file depth
    localparam int REG_COUNT = 32;

endpackage

// ==== hw/dlx_ex_if.sv ====
`timescale 1ns/1ps

interface dlx_ex_if ();

    // decode/execute register contents
    logic                  valid;
    dlx_isa_pkg::word_t    next_pc;
    // register values as read in decode
    dlx_isa_pkg::word_t    op_a;
    dlx_isa_pkg::word_t    op_b;
    // extended immediate and transfer offset
    dlx_isa_pkg::word_t    imm;
    dlx_isa_pkg::word_t    offset;
    // source numbers kept for forwarding
    dlx_isa_pkg::reg_idx_t rs1;
    dlx_isa_pkg::reg_idx_t rs2;
    dlx_isa_pkg::reg_idx_t dest;
    logic                  reg_write;
    logic                  use_imm;
    dlx_pipe_pkg::alu_op_t alu_op;
    logic                  is_beqz;
    logic                  is_bnez;
    logic                  is_jump;

    modport decode (
        output valid, next_pc, op_a, op_b, imm, offset, rs1, rs2, dest,
        output reg_write, use_imm, alu_op, is_beqz, is_bnez, is_jump
    );

    modport alu (input valid, op_a, op_b, imm, rs1, rs2, dest, reg_write, use_imm, alu_op);

    modport branch (input valid, next_pc, op_a, offset, rs1, is_beqz, is_bnez, is_jump);

endinterface

// ==== hw/dlx_fetch.sv ====
`timescale 1ns/1ps

module dlx_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  dlx_isa_pkg::word_t redirect_addr,
    output dlx_isa_pkg::word_t imem_addr,
    input  dlx_isa_pkg::word_t imem_data,
    output logic               id_valid,
    output dlx_isa_pkg::word_t id_instr,
    output dlx_isa_pkg::word_t id_next_pc
);

    // program counter and its sequential successor
    dlx_isa_pkg::word_t pc;
    dlx_isa_pkg::word_t pc_plus;

    assign pc_plus = pc + dlx_pipe_pkg::PC_STEP;

    // imem answers in the same cycle
    assign imem_addr = pc;

    //////////////////////////////////////////////////
    // pc update
    // redirect comes from the memory stage, so three
    // sequential fetches have already gone out
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= dlx_pipe_pkg::RESET_PC;
            id_valid <= 1'b0;
        end else begin
            pc       <= redirect ? redirect_addr : pc_plus;
            id_valid <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // fetch/decode register payload
    always_ff @(posedge clk) begin
        id_instr   <= imem_data;
        // branch targets are relative to this value
        id_next_pc <= pc_plus;
    end

endmodule

// ==== hw/dlx_decode.sv ====
`timescale 1ns/1ps

module dlx_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  dlx_isa_pkg::word_t    id_instr,
    input  dlx_isa_pkg::word_t    id_next_pc,
    input  logic                  wb_en,
    input  dlx_isa_pkg::reg_idx_t wb_reg,
    input  dlx_isa_pkg::word_t    wb_data,
    dlx_ex_if.decode              ex
);

    // instruction fields
    dlx_isa_pkg::opcode_t  opcode;
    dlx_isa_pkg::func_t    func;
    dlx_isa_pkg::reg_idx_t rs1;
    dlx_isa_pkg::reg_idx_t rs2;
    dlx_isa_pkg::reg_idx_t rd;
    dlx_isa_pkg::imm16_t   imm16;
    dlx_isa_pkg::imm26_t   imm26;

    // decoded controls
    dlx_pipe_pkg::alu_op_t alu_op;
    logic                  reg_write;
    logic                  use_imm;
    logic                  zero_ext;
    logic                  dest_is_rd;
    logic                  is_beqz;
    logic                  is_bnez;
    logic                  is_jump;
    dlx_isa_pkg::reg_idx_t dest;
    dlx_isa_pkg::word_t    imm_ext;
    dlx_isa_pkg::word_t    offset_ext;

    // register file
    dlx_isa_pkg::word_t    regs [dlx_pipe_pkg::REG_COUNT];
    dlx_isa_pkg::word_t    rs1_val;
    dlx_isa_pkg::word_t    rs2_val;

    assign opcode = id_instr[dlx_isa_pkg::OPCODE_MSB:dlx_isa_pkg::OPCODE_LSB];
    assign func   = id_instr[dlx_isa_pkg::FUNC_MSB:dlx_isa_pkg::FUNC_LSB];
    assign rs1    = id_instr[dlx_isa_pkg::RS1_MSB:dlx_isa_pkg::RS1_LSB];
    assign rs2    = id_instr[dlx_isa_pkg::RS2_MSB:dlx_isa_pkg::RS2_LSB];
    assign rd     = id_instr[dlx_isa_pkg::RD_MSB:dlx_isa_pkg::RD_LSB];
    assign imm16  = id_instr[dlx_isa_pkg::IMM16_MSB:dlx_isa_pkg::IMM16_LSB];
    assign imm26  = id_instr[dlx_isa_pkg::IMM26_MSB:dlx_isa_pkg::IMM26_LSB];

    //////////////////////////////////////////////////
    // control decode
    always_comb begin
        alu_op     = dlx_pipe_pkg::ALU_ADD;
        reg_write  = 1'b0;
        use_imm    = 1'b1;
        zero_ext   = 1'b0;
        dest_is_rd = 1'b0;
        is_beqz    = 1'b0;
        is_bnez    = 1'b0;
        is_jump    = 1'b0;
        case (opcode)
            dlx_isa_pkg::OP_RTYPE: begin
                use_imm    = 1'b0;
                dest_is_rd = 1'b1;
                reg_write  = 1'b1;
                case (func)
                    dlx_isa_pkg::FUNC_ADD: alu_op = dlx_pipe_pkg::ALU_ADD;
                    dlx_isa_pkg::FUNC_SUB: alu_op = dlx_pipe_pkg::ALU_SUB;
                    dlx_isa_pkg::FUNC_AND: alu_op = dlx_pipe_pkg::ALU_AND;
                    dlx_isa_pkg::FUNC_OR:  alu_op = dlx_pipe_pkg::ALU_OR;
                    dlx_isa_pkg::FUNC_XOR: alu_op = dlx_pipe_pkg::ALU_XOR;
                    dlx_isa_pkg::FUNC_SLT: alu_op = dlx_pipe_pkg::ALU_SLT;
                    // unknown function, no write
                    default:               reg_write = 1'b0;
                endcase
            end
            dlx_isa_pkg::OP_ADDI: reg_write = 1'b1;
            dlx_isa_pkg::OP_SLTI: begin
                alu_op    = dlx_pipe_pkg::ALU_SLT;
                reg_write = 1'b1;
            end
            // logic immediates are zero extended
            dlx_isa_pkg::OP_ANDI: begin
                alu_op    = dlx_pipe_pkg::ALU_AND;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
            end
            dlx_isa_pkg::OP_ORI: begin
                alu_op    = dlx_pipe_pkg::ALU_OR;
                reg_write = 1'b1;
                zero_ext  = 1'b1;
            end
            dlx_isa_pkg::OP_BEQZ: is_beqz = 1'b1;
            dlx_isa_pkg::OP_BNEZ: is_bnez = 1'b1;
            dlx_isa_pkg::OP_J:    is_jump = 1'b1;
            default: begin
            end
        endcase
    end

    assign dest = dest_is_rd ? rd : rs2;

    assign imm_ext = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    // j takes the 26-bit offset, branches the 16-bit one
    assign offset_ext = is_jump ? {{6{imm26[25]}}, imm26} : {{16{imm16[15]}}, imm16};

    //////////////////////////////////////////////////
    // register file, r0 reads zero
    always_ff @(posedge clk) begin
        if (wb_en && (wb_reg != '0)) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // write-through when writeback targets the same register
    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb_en && (wb_reg == rs1)) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb_en && (wb_reg == rs2)) ? wb_data : regs[rs2];

    //////////////////////////////////////////////////
    // decode/execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid     <= 1'b0;
            ex.reg_write <= 1'b0;
            ex.is_beqz   <= 1'b0;
            ex.is_bnez   <= 1'b0;
            ex.is_jump   <= 1'b0;
        end else begin
            ex.valid     <= id_valid;
            ex.reg_write <= reg_write;
            ex.is_beqz   <= is_beqz;
            ex.is_bnez   <= is_bnez;
            ex.is_jump   <= is_jump;
        end
    end

    always_ff @(posedge clk) begin
        ex.next_pc <= id_next_pc;
        ex.op_a    <= rs1_val;
        ex.op_b    <= rs2_val;
        ex.imm     <= imm_ext;
        ex.offset  <= offset_ext;
        ex.rs1     <= rs1;
        ex.rs2     <= rs2;
        ex.dest    <= dest;
        ex.use_imm <= use_imm;
        ex.alu_op  <= alu_op;
    end

endmodule

// ==== hw/dlx_alu.sv ====
`timescale 1ns/1ps

module dlx_alu (
    dlx_ex_if.alu                 ex,
    input  dlx_isa_pkg::word_t    mem_result,
    input  dlx_isa_pkg::reg_idx_t mem_dest,
    input  logic                  mem_write,
    output dlx_isa_pkg::word_t    alu_result,
    output dlx_isa_pkg::reg_idx_t alu_dest,
    output logic                  alu_write
);

    // forwarding selects
    logic               fwd_a;
    logic               fwd_b;
    dlx_isa_pkg::word_t opnd_a;
    dlx_isa_pkg::word_t reg_b;
    dlx_isa_pkg::word_t opnd_b;

    //////////////////////////////////////////////////
    // memory-stage forwarding
    // only the producer one slot ahead is covered
    assign fwd_a = mem_write && (mem_dest != '0) && (mem_dest == ex.rs1);
    assign fwd_b = mem_write && (mem_dest != '0) && (mem_dest == ex.rs2);

    assign opnd_a = fwd_a ? mem_result : ex.op_a;
    assign reg_b  = fwd_b ? mem_result : ex.op_b;
    // immediate wins over the second register
    assign opnd_b = ex.use_imm ? ex.imm : reg_b;

    //////////////////////////////////////////////////
    // operations
    always_comb begin
        case (ex.alu_op)
            dlx_pipe_pkg::ALU_ADD: alu_result = opnd_a + opnd_b;
            dlx_pipe_pkg::ALU_SUB: alu_result = opnd_a - opnd_b;
            dlx_pipe_pkg::ALU_AND: alu_result = opnd_a & opnd_b;
            dlx_pipe_pkg::ALU_OR:  alu_result = opnd_a | opnd_b;
            dlx_pipe_pkg::ALU_XOR: alu_result = opnd_a ^ opnd_b;
            // two's complement compare
            dlx_pipe_pkg::ALU_SLT: alu_result = {31'b0, $signed(opnd_a) < $signed(opnd_b)};
            default:               alu_result = '0;
        endcase
    end

    assign alu_dest = ex.dest;

    // bubbles and r0 targets never write
    assign alu_write = ex.valid && ex.reg_write && (ex.dest != '0);

endmodule

// ==== hw/dlx_branch.sv ====
`timescale 1ns/1ps

module dlx_branch (
    dlx_ex_if.branch              ex,
    input  dlx_isa_pkg::word_t    mem_result,
    input  dlx_isa_pkg::reg_idx_t mem_dest,
    input  logic                  mem_write,
    output logic                  leap,
    output dlx_isa_pkg::word_t    leap_addr
);

    logic               fwd;
    dlx_isa_pkg::word_t test_val;
    logic               is_zero;

    // tested operand, same source as alu operand a
    assign fwd      = mem_write && (mem_dest != '0) && (mem_dest == ex.rs1);
    assign test_val = fwd ? mem_result : ex.op_a;
    assign is_zero  = (test_val == '0);

    //////////////////////////////////////////////////
    // transfer decision
    // target is relative to the address after the transfer
    assign leap_addr = ex.next_pc + ex.offset;

    assign leap = ex.valid &&
                  (ex.is_jump ||
                   (ex.is_beqz && is_zero) ||
                   (ex.is_bnez && !is_zero));

endmodule

// ==== hw/dlx_retire.sv ====
`timescale 1ns/1ps

module dlx_retire (
    input  logic                  clk,
    input  logic                  rst,
    input  dlx_isa_pkg::word_t    alu_result,
    input  dlx_isa_pkg::reg_idx_t alu_dest,
    input  logic                  alu_write,
    input  logic                  leap,
    input  dlx_isa_pkg::word_t    leap_addr,
    output dlx_isa_pkg::word_t    mem_result,
    output dlx_isa_pkg::reg_idx_t mem_dest,
    output logic                  mem_write,
    output logic                  redirect,
    output dlx_isa_pkg::word_t    redirect_addr,
    output logic                  wb_en,
    output dlx_isa_pkg::reg_idx_t wb_reg,
    output dlx_isa_pkg::word_t    wb_data
);

    //////////////////////////////////////////////////
    // control bits of both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_write <= 1'b0;
            redirect  <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            // memory stage, feeds forwarding and fetch
            mem_write <= alu_write;
            redirect  <= leap;
            // writeback stage
            wb_en     <= mem_write;
        end
    end

    //////////////////////////////////////////////////
    // payload registers
    always_ff @(posedge clk) begin
        mem_result    <= alu_result;
        mem_dest      <= alu_dest;
        redirect_addr <= leap_addr;
        // no data memory, memory stage passes the result on
        wb_reg        <= mem_dest;
        wb_data       <= mem_result;
    end

endmodule

// ==== hw/dlx_core.sv ====
`timescale 1ns/1ps

module dlx_core (
    input  logic                  clk,
    input  logic                  rst,
    output dlx_isa_pkg::word_t    imem_addr,
    input  dlx_isa_pkg::word_t    imem_data,
    output logic                  wb_en,
    output dlx_isa_pkg::reg_idx_t wb_reg,
    output dlx_isa_pkg::word_t    wb_data
);

    // fetch to decode
    logic                  id_valid;
    dlx_isa_pkg::word_t    id_instr;
    dlx_isa_pkg::word_t    id_next_pc;

    // execute to retire
    dlx_isa_pkg::word_t    alu_result;
    dlx_isa_pkg::reg_idx_t alu_dest;
    logic                  alu_write;
    logic                  leap;
    dlx_isa_pkg::word_t    leap_addr;

    // memory stage back to execute and fetch
    dlx_isa_pkg::word_t    mem_result;
    dlx_isa_pkg::reg_idx_t mem_dest;
    logic                  mem_write;
    logic                  redirect;
    dlx_isa_pkg::word_t    redirect_addr;

    // decode/execute register
    dlx_ex_if ex_bus ();

    //////////////////////////////////////////////////
    // stages
    dlx_fetch i_dlx_fetch (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .id_valid      (id_valid),
        .id_instr      (id_instr),
        .id_next_pc    (id_next_pc)
    );

    dlx_decode i_dlx_decode (
        .clk        (clk),
        .rst        (rst),
        .id_valid   (id_valid),
        .id_instr   (id_instr),
        .id_next_pc (id_next_pc),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .ex         (ex_bus)
    );

    dlx_alu i_dlx_alu (
        .ex         (ex_bus),
        .mem_result (mem_result),
        .mem_dest   (mem_dest),
        .mem_write  (mem_write),
        .alu_result (alu_result),
        .alu_dest   (alu_dest),
        .alu_write  (alu_write)
    );

    dlx_branch i_dlx_branch (
        .ex         (ex_bus),
        .mem_result (mem_result),
        .mem_dest   (mem_dest),
        .mem_write  (mem_write),
        .leap       (leap),
        .leap_addr  (leap_addr)
    );

    // memory and writeback registers
    dlx_retire i_dlx_retire (
        .clk           (clk),
        .rst           (rst),
        .alu_result    (alu_result),
        .alu_dest      (alu_dest),
        .alu_write     (alu_write),
        .leap          (leap),
        .leap_addr     (leap_addr),
        .mem_result    (mem_result),
        .mem_dest      (mem_dest),
        .mem_write     (mem_write),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data)
    );

endmodule

// ==== test/dlx_core_tb.sv ====
`timescale 1ns/1ps

module dlx_core_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_WORDS    = 256;
    localparam int MAX_WRITES   = 128;
    localparam int QUIET_CYCLES = 3;
    localparam int SEED         = 67;

    // add r0, r0, r0 for addresses past the memory model
    localparam dlx_isa_pkg::word_t NOP_WORD =
        {dlx_isa_pkg::OP_RTYPE, 20'd0, dlx_isa_pkg::FUNC_ADD};

    // dut ports
    logic                  clk;
    logic                  rst;
    dlx_isa_pkg::word_t    imem_addr;
    dlx_isa_pkg::word_t    imem_data;
    logic                  wb_en;
    dlx_isa_pkg::reg_idx_t wb_reg;
    dlx_isa_pkg::word_t    wb_data;

    // program image and expected writeback sequence
    dlx_isa_pkg::word_t    prog     [MEM_WORDS];
    dlx_isa_pkg::reg_idx_t exp_reg  [MAX_WRITES];
    dlx_isa_pkg::word_t    exp_data [MAX_WRITES];
    int                    prog_len;
    int                    exp_count;
    int                    wr_idx;
    int                    errors;
    logic                  loaded;

    dlx_core i_dlx_core (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // combinational instruction port with a 1 KiB window at zero
    assign imem_data = (imem_addr[31:10] == '0) ? prog[imem_addr[9:2]] : NOP_WORD;

    //////////////////////////////////////////////////
    // helpers

    // add into r0 from random sources
    function automatic dlx_isa_pkg::word_t filler_word(input logic [31:0] rnd);
        filler_word = {dlx_isa_pkg::OP_RTYPE, rnd[4:0], rnd[9:5], 10'd0,
                       dlx_isa_pkg::FUNC_ADD};
    endfunction

    // I lines fill the program and W lines the expected writes
    task automatic load_stimulus();
        int                 fd;
        int                 n;
        int                 reg_num;
        dlx_isa_pkg::word_t value;
        logic [8*128-1:0]   line;
        fd = $fopen("test/dlx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/dlx_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    if ($sscanf(line, "I %h", value) == 1) begin
                        if (prog_len < MEM_WORDS) begin
                            prog[prog_len] = value;
                            prog_len++;
                        end else begin
                            $display("program does not fit in %0d words", MEM_WORDS);
                            errors++;
                        end
                    end else if ($sscanf(line, "W %d %h", reg_num, value) == 2) begin
                        if (exp_count < MAX_WRITES) begin
                            exp_reg[exp_count]  = reg_num[4:0];
                            exp_data[exp_count] = value;
                            exp_count++;
                        end else begin
                            $display("more than %0d expected writes", MAX_WRITES);
                            errors++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // pc parked at the reset address with nothing retiring
    task automatic check_reset_state();
        if (imem_addr !== dlx_pipe_pkg::RESET_PC) begin
            $display("FAILED imem_addr in reset: got 0x%08h, expected 0x%08h",
                     imem_addr, dlx_pipe_pkg::RESET_PC);
            errors++;
        end
        if (wb_en !== 1'b0) begin
            $display("FAILED wb_en in reset: got 0x%h, expected 0x0", wb_en);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // writeback checker takes one expected entry per wb_en
    always @(posedge clk) begin
        if (wb_en === 1'b1) begin
            if (wr_idx < exp_count) begin
                if (wb_reg !== exp_reg[wr_idx]) begin
                    $display("FAILED wb_reg at write %0d: got 0x%02h, expected 0x%02h",
                             wr_idx, wb_reg, exp_reg[wr_idx]);
                    errors++;
                end
                if (wb_data !== exp_data[wr_idx]) begin
                    $display("FAILED wb_data at write %0d: got 0x%08h, expected 0x%08h",
                             wr_idx, wb_data, exp_data[wr_idx]);
                    errors++;
                end
                wr_idx++;
            end else begin
                $display("write to r%0d after the last expected write", wb_reg);
                errors++;
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        rst       <= 1'b1;
        prog_len  = 0;
        exp_count = 0;
        wr_idx    = 0;
        errors    = 0;
        loaded    = 1'b0;
        void'($urandom(SEED));
        // fill every word before the program overwrites the low ones
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = filler_word($urandom);
        end
        load_stimulus();
        if (exp_count == 0) begin
            $display("stimulus file holds no expected writes");
            errors++;
        end
        loaded = 1'b1;

        // four cycles of reset with the state checked from the second edge on
        @(posedge clk);
        repeat (3) begin
            @(posedge clk);
            check_reset_state();
        end
        rst <= 1'b0;
        @(posedge clk);
        check_reset_state();

        wait (wr_idx == exp_count);
        // pipeline must go quiet after the last write
        repeat (QUIET_CYCLES) @(posedge clk);
        @(negedge clk);

        $display("errors: %0d, writes checked: %0d of %0d", errors, wr_idx, exp_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog sized from program and write counts
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = (prog_len + exp_count + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout after %0d ns with %0d of %0d writes seen, errors: %0d",
                 limit_ns, wr_idx, exp_count, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== test/dlx_stimulus.txt ====
# I <word hex>: program word, stored in address order from zero
# W <reg decimal> <data hex>: expected writeback, in retire order
I 20010005  # 00 addi r1, r0, 5
I 2022FFFD  # 01 addi r2, r1, -3
I 2003FFF9  # 02 addi r3, r0, -7
I 00232020  # 03 add r4, r1, r3
I 00412822  # 04 sub r5, r2, r1
I 0062302A  # 05 slt r6, r3, r2
I 0043382A  # 06 slt r7, r2, r3
I 00854026  # 07 xor r8, r4, r5
I 01044824  # 08 and r9, r8, r4
I 01215025  # 09 or r10, r9, r1
I 286BFFFF  # 10 slti r11, r3, -1
I 282CFFFF  # 11 slti r12, r1, -1
I 306DFFF0  # 12 andi r13, r3, 0xfff0
I 340E8001  # 13 ori r14, r0, 0x8001
I 200F8001  # 14 addi r15, r0, 0x8001
I 20200009  # 15 addi r0, r1, 9
I 000E8020  # 16 add r16, r0, r14
I 22110001  # 17 addi r17, r16, 1
I 22310001  # 18 addi r17, r17, 1
I 02309022  # 19 sub r18, r17, r16
I 12400100  # 20 beqz r18, untaken
I 20130011  # 21 addi r19, r0, 0x11
I 15800100  # 22 bnez r12, untaken
I 20140022  # 23 addi r20, r0, 0x22
I 16600014  # 24 bnez r19, to 30
I 20150001  # 25 addi r21, r0, 1
I 22B60001  # 26 addi r22, r21, 1
I 20170003  # 27 addi r23, r0, 3
I 20180BAD  # 28 skipped
I 20190BAD  # 29 skipped
I 10E00014  # 30 beqz r7, to 36
I 20180031  # 31 addi r24, r0, 0x31
I 02D5C820  # 32 add r25, r22, r21
I 233A0010  # 33 addi r26, r25, 0x10
I 201B0BAD  # 34 skipped
I 201B0BAD  # 35 skipped
I 08000014  # 36 j to 42
I 201B0037  # 37 addi r27, r0, 0x37
I 0368F826  # 38 xor r31, r27, r8
I 00000020  # 39 nop
I 20010BAD  # 40 skipped
I 20010BAD  # 41 skipped
I 201C0002  # 42 addi r28, r0, 2
I 00000020  # 43 nop
I 00000020  # 44 nop
I 239CFFFF  # 45 addi r28, r28, -1
I 1780FFF8  # 46 bnez r28, back to 45
I 201D0047  # 47 addi r29, r0, 0x47
I 00000020  # 48 nop
I 00000020  # 49 nop
I 03AAF020  # 50 add r30, r29, r10
W 1 00000005
W 2 00000002
W 3 FFFFFFF9
W 4 FFFFFFFE
W 5 FFFFFFFD
W 6 00000001
W 7 00000000
W 8 00000003
W 9 00000002
W 10 00000007
W 11 00000001
W 12 00000000
W 13 0000FFF0
W 14 00008001
W 15 FFFF8001
W 16 00008001
W 17 00008002
W 17 00008003
W 18 00000002
W 19 00000011
W 20 00000022
W 21 00000001
W 22 00000002
W 23 00000003
W 24 00000031
W 25 00000003
W 26 00000013
W 27 00000037
W 31 00000034
W 28 00000002
W 28 00000001
W 29 00000047
W 28 00000000
W 29 00000047
W 30 0000004E

// ==== src.f ====
hw/dlx_isa_pkg.sv
hw/dlx_pipe_pkg.sv
hw/dlx_ex_if.sv
hw/dlx_fetch.sv
hw/dlx_decode.sv
hw/dlx_alu.sv
hw/dlx_branch.sv
hw/dlx_retire.sv
hw/dlx_core.sv
test/dlx_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module dlx_core_tb -o sim_dlx_core
./obj_dir/sim_dlx_core > sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
